// ==== pipeline_params.svh ====
`ifndef PIPELINE_PARAMS_SVH
`define PIPELINE_PARAMS_SVH

// Strand geometry
`define STRANDS_PER_CORE 4
`define STRAND_INDEX_WIDTH 2

// Per-strand scalar register file
`define REG_COUNT 16
`define REG_IDX_WIDTH 4

`define DATA_WIDTH 32          // Registers and I/O data
`define ADDR_WIDTH 16          // Instruction word address
`define INSTR_WIDTH 32

`endif

// ==== pipeline_pkg.sv ====
`include "pipeline_params.svh"

package pipeline_pkg;

	typedef enum logic [3:0]
	{
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,     // rd = rs1 + simm
		OP_LUI  = 4'h7,     // rd = imm16 << 16
		OP_BEQZ = 4'h8,     // Relative to own pc
		OP_JUMP = 4'h9,
		OP_OUT  = 4'ha,     // I/O write of rs1 to imm16
		OP_HALT = 4'hb      // Disables own strand
	} opcode_t;

	typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [`STRAND_INDEX_WIDTH-1:0] strand_t;

	// Instruction word layout, low bit of each field
	// opcode 31:28, rd 27:24, rs1 23:20, rs2 19:16, imm16 15:0
	localparam int OPCODE_LSB = 28;
	localparam int OPCODE_WIDTH = 4;
	localparam int RD_LSB = 24;
	localparam int RS1_LSB = 20;
	localparam int RS2_LSB = 16;
	localparam int IMM_LSB = 0;
	localparam int IMM_WIDTH = 16;

endpackage

// ==== pipeline_ifs.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

// Fetch to decode, one slot per cycle
interface fetch_issue_if import pipeline_pkg::*;
	();

	logic valid;                         // Single cycle strobe
	strand_t strand;
	logic [`ADDR_WIDTH-1:0] pc;
	logic [`INSTR_WIDTH-1:0] instruction; // Straight from imem

	modport source(output valid, strand, pc, instruction);
	modport sink(input valid, strand, pc, instruction);
endinterface

// Decoded bundle into execute
interface decode_issue_if import pipeline_pkg::*;
	();

	logic valid;
	strand_t strand;
	logic [`ADDR_WIDTH-1:0] pc;          // For branch targets
	opcode_t opcode;
	reg_idx_t rd;
	logic [`DATA_WIDTH-1:0] op1;
	logic [`DATA_WIDTH-1:0] op2;
	logic [`DATA_WIDTH-1:0] imm;         // Already extended or shifted

	modport source(output valid, strand, pc, opcode, rd, op1, op2, imm);
	modport sink(input valid, strand, pc, opcode, rd, op1, op2, imm);
endinterface

// Result write into the register file
interface writeback_if import pipeline_pkg::*;
	();

	logic valid;
	strand_t strand;
	reg_idx_t rd;
	logic [`DATA_WIDTH-1:0] value;

	modport source(output valid, strand, rd, value);
	modport sink(input valid, strand, rd, value);
endinterface

// ==== instruction_fetch_stage.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

module instruction_fetch_stage import pipeline_pkg::*;
	(input                                clk,
	input                                 reset,
	output logic                          imem_request,
	output logic [`ADDR_WIDTH-1:0]        imem_addr,
	input [`INSTR_WIDTH-1:0]              imem_data,
	input                                 redirect_en,
	input strand_t                        redirect_strand,
	input [`ADDR_WIDTH-1:0]               redirect_pc,
	input                                 halt_strand_en,
	input strand_t                        halt_strand,
	output logic [`STRANDS_PER_CORE-1:0]  strand_enable,
	fetch_issue_if.source                 issue);

	localparam int REGION_WORDS = 64;    // Start address spacing per strand

	strand_t slot;                                          // Strand owning this cycle
	logic [`ADDR_WIDTH-1:0] strand_pc[`STRANDS_PER_CORE];   // Next fetch address

	// Disabled strand leaves a bubble in its slot
	assign imem_request = strand_enable[slot];
	assign imem_addr = strand_pc[slot];
	assign issue.instruction = imem_data;   // Memory answers one cycle later

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			slot <= '0;
			strand_enable <= '1;                 // All strands run out of reset
			for (int s = 0; s < `STRANDS_PER_CORE; s++)
				strand_pc[s] <= `ADDR_WIDTH'(s * REGION_WORDS);
			issue.valid <= 1'b0;
		end
		else
		begin
			slot <= slot + 1'b1;                 // Fixed rotation
			if (imem_request)
				strand_pc[slot] <= strand_pc[slot] + 1'b1;

			// Redirect is for a strand two slots back, never the current one
			if (redirect_en)
				strand_pc[redirect_strand] <= redirect_pc;

			if (halt_strand_en)
				strand_enable[halt_strand] <= 1'b0;

			issue.valid <= imem_request;
		end
	end

	// Tag travels with the returning word
	always_ff @(posedge clk)
	begin
		issue.strand <= slot;
		issue.pc <= strand_pc[slot];
	end
endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

module decode_stage import pipeline_pkg::*;
	(input                             clk,
	input                              reset,
	fetch_issue_if.sink                issue,
	output reg_idx_t                   rf_sel1,
	output reg_idx_t                   rf_sel2,
	output strand_t                    rf_strand,
	input [`DATA_WIDTH-1:0]            rf_value1,
	input [`DATA_WIDTH-1:0]            rf_value2,
	decode_issue_if.source             decoded);

	opcode_t opcode;
	reg_idx_t rd;
	logic [IMM_WIDTH-1:0] imm16;
	logic [`DATA_WIDTH-1:0] imm_value;    // Extended immediate

	// Field split
	assign opcode = opcode_t'(issue.instruction[OPCODE_LSB +: OPCODE_WIDTH]);
	assign rd = issue.instruction[RD_LSB +: `REG_IDX_WIDTH];
	assign imm16 = issue.instruction[IMM_LSB +: IMM_WIDTH];

	// Register file read, combinational in this cycle
	assign rf_sel1 = issue.instruction[RS1_LSB +: `REG_IDX_WIDTH];
	assign rf_sel2 = issue.instruction[RS2_LSB +: `REG_IDX_WIDTH];
	assign rf_strand = issue.strand;

	always_comb
	begin
		if (opcode == OP_LUI)
			imm_value = {imm16, {(`DATA_WIDTH - IMM_WIDTH){1'b0}}};   // Upper half
		else
			imm_value = {{(`DATA_WIDTH - IMM_WIDTH){imm16[IMM_WIDTH-1]}}, imm16};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			decoded.valid <= 1'b0;
		else
			decoded.valid <= issue.valid;
	end

	// Payload loads every cycle, qualified by valid downstream
	always_ff @(posedge clk)
	begin
		decoded.strand <= issue.strand;
		decoded.pc <= issue.pc;
		decoded.opcode <= opcode;
		decoded.rd <= rd;
		decoded.op1 <= rf_value1;
		decoded.op2 <= rf_value2;
		decoded.imm <= imm_value;
	end
endmodule

// ==== scalar_register_file.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

module scalar_register_file import pipeline_pkg::*;
	(input                         clk,
	input                          reset,
	input strand_t                 rf_strand,
	input reg_idx_t                rf_sel1,
	input reg_idx_t                rf_sel2,
	output logic [`DATA_WIDTH-1:0] rf_value1,
	output logic [`DATA_WIDTH-1:0] rf_value2,
	writeback_if.sink              writeback);

	// Strand number forms the upper index bits
	logic [`DATA_WIDTH-1:0] registers[`STRANDS_PER_CORE * `REG_COUNT];

	// Same strand never writes and reads in one cycle, no bypass
	assign rf_value1 = registers[{rf_strand, rf_sel1}];
	assign rf_value2 = registers[{rf_strand, rf_sel2}];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `STRANDS_PER_CORE * `REG_COUNT; i++)
				registers[i] <= '0;
		end
		else if (writeback.valid)
			registers[{writeback.strand, writeback.rd}] <= writeback.value;
	end
endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

module execute_stage import pipeline_pkg::*;
	(input                             clk,
	input                              reset,
	decode_issue_if.sink               decoded,
	output logic                       redirect_en,
	output strand_t                    redirect_strand,
	output logic [`ADDR_WIDTH-1:0]     redirect_pc,
	output logic                       halt_strand_en,
	output strand_t                    halt_strand,
	output logic                       io_write_en,
	output logic [`DATA_WIDTH-1:0]     io_address,
	output logic [`DATA_WIDTH-1:0]     io_write_data,
	output strand_t                    io_strand,
	writeback_if.source                writeback);

	logic [`DATA_WIDTH-1:0] result;   // ALU output
	logic writes_rd;                  // Opcode targets rd
	logic branch_taken;

	always_comb
	begin
		result = '0;
		writes_rd = 1'b1;
		case (decoded.opcode)
			OP_ADD: result = decoded.op1 + decoded.op2;
			OP_SUB: result = decoded.op1 - decoded.op2;
			OP_AND: result = decoded.op1 & decoded.op2;
			OP_OR: result = decoded.op1 | decoded.op2;
			OP_XOR: result = decoded.op1 ^ decoded.op2;
			OP_ADDI: result = decoded.op1 + decoded.imm;
			OP_LUI: result = decoded.imm;      // Shifted in decode
			default: writes_rd = 1'b0;         // Branches, OUT, HALT, NOP
		endcase
	end

	// Not-taken BEQZ needs nothing, fetch already moved to pc + 1
	assign branch_taken = decoded.opcode == OP_JUMP
		|| (decoded.opcode == OP_BEQZ && decoded.op1 == '0);

	assign redirect_en = decoded.valid && branch_taken;
	assign redirect_strand = decoded.strand;
	assign redirect_pc = decoded.pc + decoded.imm[`ADDR_WIDTH-1:0];

	assign halt_strand_en = decoded.valid && decoded.opcode == OP_HALT;
	assign halt_strand = decoded.strand;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			writeback.valid <= 1'b0;
			io_write_en <= 1'b0;
		end
		else
		begin
			writeback.valid <= decoded.valid && writes_rd;
			io_write_en <= decoded.valid && decoded.opcode == OP_OUT;
		end
	end

	always_ff @(posedge clk)
	begin
		writeback.strand <= decoded.strand;
		writeback.rd <= decoded.rd;
		writeback.value <= result;
		io_address <= `DATA_WIDTH'(decoded.imm[IMM_WIDTH-1:0]);   // Raw imm16, no sign
		io_write_data <= decoded.op1;                             // Value of rs1
		io_strand <= decoded.strand;
	end
endmodule

// ==== instruction_pipeline.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

module instruction_pipeline import pipeline_pkg::*;
	(input                                 clk,
	input                                  reset,
	output logic                           imem_request,
	output logic [`ADDR_WIDTH-1:0]         imem_addr,
	input [`INSTR_WIDTH-1:0]               imem_data,
	output logic                           io_write_en,
	output logic [`DATA_WIDTH-1:0]         io_address,
	output logic [`DATA_WIDTH-1:0]         io_write_data,
	output logic [`STRAND_INDEX_WIDTH-1:0] io_strand,
	output logic                           halt);

	logic redirect_en;                         // Taken branch from execute
	strand_t redirect_strand;
	logic [`ADDR_WIDTH-1:0] redirect_pc;
	logic halt_strand_en;
	strand_t halt_strand;
	logic [`STRANDS_PER_CORE-1:0] strand_enable;
	reg_idx_t rf_sel1;
	reg_idx_t rf_sel2;
	strand_t rf_strand;
	logic [`DATA_WIDTH-1:0] rf_value1;
	logic [`DATA_WIDTH-1:0] rf_value2;

	fetch_issue_if fetch_issue();
	decode_issue_if decode_issue();
	writeback_if rf_writeback();

	assign halt = strand_enable == '0;         // Every strand has run HALT

	instruction_fetch_stage instruction_fetch_stage(.*, .issue(fetch_issue));
	decode_stage decode_stage(.*, .issue(fetch_issue), .decoded(decode_issue));
	scalar_register_file scalar_register_file(.*, .writeback(rf_writeback));
	execute_stage execute_stage(.*, .decoded(decode_issue), .writeback(rf_writeback));
endmodule

// ==== tb_instruction_pipeline.sv ====
`timescale 1ns/1ns
`include "pipeline_params.svh"

module tb_instruction_pipeline import pipeline_pkg::*;
	();

	localparam int REGION_WORDS = 64;       // Program region per strand
	localparam int HALT_TIMEOUT = 3000;     // Cycles until every strand must halt

	logic clk;
	logic reset;
	logic imem_request;
	logic [`ADDR_WIDTH-1:0] imem_addr;
	logic [`INSTR_WIDTH-1:0] imem_data;
	logic io_write_en;
	logic [`DATA_WIDTH-1:0] io_address;
	logic [`DATA_WIDTH-1:0] io_write_data;
	logic [`STRAND_INDEX_WIDTH-1:0] io_strand;
	logic halt;

	logic [`INSTR_WIDTH-1:0] mem[`STRANDS_PER_CORE * REGION_WORDS];   // 256 words
	logic [47:0] expected[`STRANDS_PER_CORE][$];   // {imm16 address, data} per strand
	logic [31:0] rng_state = 32'd79558;
	logic [7:0] wr_ptr;                            // Assembler write address
	int errors = 0;
	int test_errors;
	int tests_passed = 0;
	int tests_failed = 0;

	instruction_pipeline DUT(.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Instruction memory answers a request on the next cycle
	initial
	begin
		logic req;
		logic [`ADDR_WIDTH-1:0] addr;
		imem_data = '0;
		forever
		begin
			@(negedge clk);
			req = imem_request;
			addr = imem_addr;
			@(posedge clk);
			#1 imem_data = req ? mem[addr[7:0]] : '0;
		end
	end

	// Monitor checks each io write against the head of its strand's list
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (io_write_en === 1'b1)
			begin
				check_value(64'(expected[io_strand].size() != 0), 64'd1,
					$sformatf("strand %0d io write with none expected", io_strand));
				if (expected[io_strand].size() != 0)
					check_value({io_address, io_write_data},
						{16'h0, expected[io_strand].pop_front()},
						$sformatf("strand %0d io write", io_strand));
			end
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic emit(input logic [3:0] op, input int rd, input int rs1, input int rs2,
		input int imm);
		logic [31:0] w;
		w = '0;
		w[OPCODE_LSB +: OPCODE_WIDTH] = op;
		w[RD_LSB +: `REG_IDX_WIDTH] = rd[3:0];
		w[RS1_LSB +: `REG_IDX_WIDTH] = rs1[3:0];
		w[RS2_LSB +: `REG_IDX_WIDTH] = rs2[3:0];
		w[IMM_LSB +: IMM_WIDTH] = imm[15:0];
		mem[wr_ptr] = w;
		wr_ptr++;
	endtask

	// Kind bit 0 adds the straight-line block, bit 1 the countdown loop
	task automatic build_program(input int s, input int kind, input int extra);
		int rd;
		logic [3:0] alu_op;
		wr_ptr = 8'(s * REGION_WORDS);
		for (int a = 0; a < REGION_WORDS; a++)
			mem[8'(s * REGION_WORDS + a)] = 32'(s * REGION_WORDS + a);   // NOP with imm as address
		if (kind[0])
		begin
			for (int i = 1; i <= 4; i++)
			begin
				emit(OP_LUI, i, 0, 0, int'(next_random()));
				emit(OP_ADDI, i, i, 0, int'(next_random()));
			end
			for (int i = 0; i < 5; i++)
			begin
				alu_op = 4'(1 + next_random() % 5);         // ADD through XOR
				rd = int'(1 + next_random() % 7);
				emit(alu_op, rd, int'(next_random() % 8), int'(next_random() % 8), 0);
				emit(OP_OUT, 0, rd, 0, 16 * s + i);
			end
		end
		if (kind[1])
		begin
			emit(OP_LUI, 8, 0, 0, 0);
			emit(OP_ADDI, 8, 8, 0, int'(1 + next_random() % 5));   // Loop count
			emit(OP_OUT, 0, 8, 0, 'h100 + s);                      // Loop top
			emit(OP_ADDI, 8, 8, 0, -1);
			emit(OP_BEQZ, 0, 8, 0, 2);                             // Exit past the jump
			emit(OP_JUMP, 0, 0, 0, -3);
			emit(OP_OUT, 0, 8, 0, 'h1ff);
		end
		for (int i = 0; i < extra; i++)
		begin
			emit(OP_ADDI, 9, 9, 0, int'(next_random()));
			emit(OP_OUT, 0, 9, 0, 'h200 + i);
		end
		emit(OP_HALT, 0, 0, 0, 0);
	endtask

	// Interprets one strand's program and queues its io writes
	function automatic void reference_run(input int s);
		logic [31:0] r[16];
		logic [15:0] pc;
		logic [15:0] next_pc;
		logic [31:0] w;
		logic [31:0] simm;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
		pc = 16'(s * REGION_WORDS);
		foreach (r[i])
			r[i] = '0;
		for (int step = 0; step < 1000; step++)
		begin
			w = mem[pc[7:0]];
			rd = w[27:24];
			rs1 = w[23:20];
			rs2 = w[19:16];
			simm = {{16{w[15]}}, w[15:0]};
			next_pc = pc + 16'd1;
			case (w[31:28])
				OP_ADD: r[rd] = r[rs1] + r[rs2];
				OP_SUB: r[rd] = r[rs1] - r[rs2];
				OP_AND: r[rd] = r[rs1] & r[rs2];
				OP_OR: r[rd] = r[rs1] | r[rs2];
				OP_XOR: r[rd] = r[rs1] ^ r[rs2];
				OP_ADDI: r[rd] = r[rs1] + simm;
				OP_LUI: r[rd] = {w[15:0], 16'h0};
				OP_BEQZ: if (r[rs1] == 32'd0) next_pc = pc + simm[15:0];
				OP_JUMP: next_pc = pc + simm[15:0];
				OP_OUT: expected[2'(s)].push_back({w[15:0], r[rs1]});
				OP_HALT: return;
				default: ;
			endcase
			pc = next_pc;
		end
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] want,
		input string msg);
		if (actual !== want)
		begin
			$display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, msg, actual, want);
			errors++;
			test_errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
	endtask

	// One nibble per strand in kinds and extras with strand 0 lowest
	task automatic run_test(input string name, input logic [15:0] kinds, input logic [15:0] extras);
		int cycles;
		test_errors = 0;
		for (int s = 0; s < `STRANDS_PER_CORE; s++)
		begin
			build_program(s, int'(kinds[4 * s +: 4]), int'(extras[4 * s +: 4]));
			expected[2'(s)].delete();
			reference_run(s);
		end
		apply_reset();
		@(negedge clk);
		check_value(64'(halt), 64'd0, "halt after reset");
		check_value(64'(io_write_en), 64'd0, "io_write_en after reset");
		cycles = 0;
		while (halt !== 1'b1 && cycles < HALT_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (halt !== 1'b1)
		begin
			$display("ERROR at %0t: halt did not rise within %0d cycles", $time, HALT_TIMEOUT);
			errors++;
			test_errors++;
		end
		else
		begin
			// Writes all arrive before the last strand halts
			for (int s = 0; s < `STRANDS_PER_CORE; s++)
				check_value(64'(expected[2'(s)].size()), 64'd0,
					$sformatf("strand %0d writes pending at halt", s));
			repeat (20)
			begin
				@(negedge clk);              // Monitor flags any late write
				check_value(64'(halt), 64'd1, "halt stays high");
				check_value(64'(imem_request), 64'd0, "imem_request after halt");
			end
		end
		if (test_errors == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("%s: %s (%0d errors)", name, test_errors == 0 ? "ok" : "failed", test_errors);
	endtask

	initial
	begin
		reset = 1'b1;
		run_test("reset state", 16'h0000, 16'h0000);
		run_test("straight line on strand 0", 16'h0001, 16'h0000);
		run_test("branch loop on strand 0", 16'h0002, 16'h0000);
		run_test("four strands", 16'h3333, 16'h2503);
		run_test("staggered halts", 16'h3021, 16'hc000);   // Strand 2 halts first
		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end
endmodule

// ==== src.f ====
+incdir+.
pipeline_pkg.sv
pipeline_ifs.sv
instruction_fetch_stage.sv
decode_stage.sv
scalar_register_file.sv
execute_stage.sv
instruction_pipeline.sv
tb_instruction_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns --top-module tb_instruction_pipeline -f src.f &&
./obj_dir/Vtb_instruction_pipeline | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
